// File: design/orbPkg.sv
`default_nettype none

package orbPkg;

	localparam int NumChannels = 4;   // fast1, fast2, slow1, slow2

	typedef logic [11:0] codeT;       // raw converter code
	typedef logic [7:0]  sampleT;     // rounded sample
	typedef logic [11:0] orbWordT;    // one frame slot word
	typedef logic [10:0] orbAddrT;    // frame number in the upper bits, slot below
	typedef logic [4:0]  slotT;       // 32 slots per frame
	typedef logic [5:0]  frameT;      // 64 frames in memory
	typedef logic [1:0]  chanIdxT;    // 0 fast1, 1 fast2, 2 slow1, 3 slow2

	localparam slotT ServiceSlot = 5'd31;   // shared by the two slow channels

	typedef struct packed {
		logic valid;                  // one-cycle strobe from the converter
		codeT code;
	} codeInT;

	typedef struct packed {
		logic    we;
		orbAddrT addr;
		orbWordT data;
	} memWriteT;

	// one word takes four cycles Start, Set, Ack, ClearAck
	typedef enum logic [2:0] {
		Idle,
		Start,
		Set,
		Ack,
		ClearAck
	} packerStateT;

endpackage

`default_nettype wire

// File: design/sampleAcquirer.sv
`timescale 1ns/1ps
`default_nettype none

module sampleAcquirer (
	input  logic                                      clk,
	input  logic                                      rst,
	input  orbPkg::codeInT [orbPkg::NumChannels-1:0]  codes,
	output logic [orbPkg::NumChannels-1:0]            push,
	output orbPkg::sampleT [orbPkg::NumChannels-1:0]  samples
);
	import orbPkg::*;

	localparam int CodeW = $bits(codeT);
	localparam int DropBits = $bits(codeT) - $bits(sampleT);
	localparam logic [CodeW:0] HalfLsb = 1 << (DropBits - 1);   // half an LSB of the sample

	// round to nearest and clip at full scale instead of wrapping to zero
	function automatic sampleT roundCode(input codeT code);
		logic [CodeW:0] sum;
		sum = {1'b0, code} + HalfLsb;
		if (sum[CodeW]) begin
			return '1;
		end
		return sum[CodeW-1 -: $bits(sampleT)];
	endfunction

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			push <= '0;
		end else begin
			for (int i = 0; i < NumChannels; i++) begin
				push[i] <= codes[i].valid;   // push lines up with the registered sample
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NumChannels; i++) begin
			if (codes[i].valid) begin
				samples[i] <= roundCode(codes[i].code);
			end
		end
	end

endmodule

`default_nettype wire

// File: design/sampleFifo.sv
`timescale 1ns/1ps
`default_nettype none

module sampleFifo #(
	parameter int FifoDepth = 16,
	parameter int BlockSize = 4
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           push,
	input  orbPkg::sampleT pushData,
	input  logic           pop,
	output orbPkg::sampleT popData,
	output logic           empty,
	output logic           done,
	output logic           overflow
);
	import orbPkg::*;

	localparam int PtrW = $clog2(FifoDepth);
	localparam int CntW = $clog2(FifoDepth + 1);

	sampleT          mem [FifoDepth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic            full;
	logic            wrEn;
	logic            rdEn;

	assign full    = (count == CntW'(FifoDepth));
	assign empty   = (count == '0);
	assign done    = (count >= CntW'(BlockSize));   // a whole block is waiting
	assign wrEn    = push && !full;                  // a push into a full buffer is lost
	assign rdEn    = pop && !empty;
	assign popData = mem[rdPtr];                      // head word shows without a pop

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wrEn) begin
				wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (rdEn) begin
				rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({wrEn, rdEn})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && full) begin
				overflow <= 1'b1;   // stays set until reset
			end
		end
	end

endmodule

`default_nettype wire

// File: design/orbPacker.sv
`timescale 1ns/1ps
`default_nettype none

module orbPacker (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic [orbPkg::NumChannels-1:0]            done,
	input  logic [orbPkg::NumChannels-1:0]            empty,
	output logic [orbPkg::NumChannels-1:0]            pop,
	input  orbPkg::sampleT [orbPkg::NumChannels-1:0]  fifoData,
	output orbPkg::memWriteT                          memWrite,
	output logic                                      busy
);
	import orbPkg::*;

	localparam logic [3:0] Fast1Last = 4'd15;   // 16 even slots per frame
	localparam logic [3:0] Fast2Last = 4'd14;   // 15 odd slots, slot 31 is reserved

	packerStateT state;
	chanIdxT     chan;         // channel being drained
	logic [3:0]  wordCnt1;
	logic [3:0]  wordCnt2;
	frameT       frameCnt1;
	frameT       frameCnt2;
	frameT       slowFrame1;   // even frames only
	frameT       slowFrame2;   // odd frames only
	slotT        slot;
	frameT       frame;

	// lowest index wins, so fast1 beats fast2 beats slow1 beats slow2
	function automatic chanIdxT pickChannel(input logic [NumChannels-1:0] req);
		chanIdxT idx;
		idx = '0;
		for (int i = NumChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				idx = chanIdxT'(i);
			end
		end
		return idx;
	endfunction

	// even slots 0, 4 .. 28 first, then 2, 6 .. 30
	function automatic slotT fast1Slot(input logic [3:0] cnt);
		return {cnt[2:0], cnt[3], 1'b0};
	endfunction

	// odd slots 1, 5 .. 29 first, then 3, 7 .. 27
	function automatic slotT fast2Slot(input logic [3:0] cnt);
		return {cnt[2:0], cnt[3], 1'b1};
	endfunction

	always_comb begin
		case (chan)
			2'd0: begin
				slot  = fast1Slot(wordCnt1);
				frame = frameCnt1;
			end
			2'd1: begin
				slot  = fast2Slot(wordCnt2);
				frame = frameCnt2;
			end
			2'd2: begin
				slot  = ServiceSlot;
				frame = slowFrame1;
			end
			default: begin
				slot  = ServiceSlot;
				frame = slowFrame2;
			end
		endcase
	end

	assign busy = (state != Idle);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state      <= Idle;
			chan       <= '0;
			wordCnt1   <= '0;
			wordCnt2   <= '0;
			frameCnt1  <= '0;
			frameCnt2  <= '0;
			slowFrame1 <= frameT'(0);
			slowFrame2 <= frameT'(1);
			pop        <= '0;
			memWrite   <= '0;
		end else begin
			case (state)
				Idle: begin
					if (|done) begin
						chan  <= pickChannel(done);
						state <= Start;
					end
				end
				Start: begin
					memWrite.addr <= {frame, slot};
					memWrite.data <= {1'b0, fifoData[chan], 3'b000};   // head word of the FIFO
					case (chan)
						2'd0: begin
							wordCnt1 <= wordCnt1 + 1'b1;   // wraps by itself after 16
							if (wordCnt1 == Fast1Last) begin
								frameCnt1 <= frameCnt1 + 1'b1;
							end
						end
						2'd1: begin
							if (wordCnt2 == Fast2Last) begin
								wordCnt2  <= '0;
								frameCnt2 <= frameCnt2 + 1'b1;
							end else begin
								wordCnt2 <= wordCnt2 + 1'b1;
							end
						end
						2'd2: slowFrame1 <= slowFrame1 + frameT'(2);
						default: slowFrame2 <= slowFrame2 + frameT'(2);
					endcase
					state <= Set;
				end
				Set: begin
					memWrite.we <= 1'b1;
					pop[chan]   <= 1'b1;   // both are high for the Ack cycle
					state       <= Ack;
				end
				Ack: begin
					memWrite.we <= 1'b0;
					pop         <= '0;
					state       <= ClearAck;
				end
				ClearAck: begin
					// the pop has landed, so empty is current here
					state <= empty[chan] ? Idle : Start;
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/orbFrameRam.sv
`timescale 1ns/1ps
`default_nettype none

module orbFrameRam (
	input  logic             clk,
	input  orbPkg::memWriteT memWrite,
	input  orbPkg::orbAddrT  rdAddr,
	output orbPkg::orbWordT  rdData
);
	import orbPkg::*;

	localparam int Depth = 2 ** $bits(orbAddrT);   // 64 frames of 32 slots

	orbWordT mem [Depth];

	always_ff @(posedge clk) begin
		if (memWrite.we) begin
			mem[memWrite.addr] <= memWrite.data;
		end
		rdData <= mem[rdAddr];   // data one cycle after the address
	end

endmodule

`default_nettype wire

// File: design/orbTop.sv
`timescale 1ns/1ps
`default_nettype none

module orbTop #(
	parameter int FifoDepth = 16,
	parameter int BlockSize = 4
) (
	input  logic                                      clk,
	input  logic                                      rst,
	input  orbPkg::codeInT [orbPkg::NumChannels-1:0]  codes,
	input  orbPkg::orbAddrT                           rdAddr,
	output orbPkg::orbWordT                           rdData,
	output logic [orbPkg::NumChannels-1:0]            overflow,
	output logic                                      busy
);
	import orbPkg::*;

	logic [NumChannels-1:0]   push;
	logic [NumChannels-1:0]   pop;
	logic [NumChannels-1:0]   empty;
	logic [NumChannels-1:0]   done;
	sampleT [NumChannels-1:0] samples;
	sampleT [NumChannels-1:0] fifoData;
	memWriteT                 memWrite;

	sampleAcquirer uAcquirer (
		.clk     (clk),
		.rst     (rst),
		.codes   (codes),
		.push    (push),
		.samples (samples)
	);

	for (genvar i = 0; i < NumChannels; i++) begin : gFifo
		sampleFifo #(
			.FifoDepth (FifoDepth),
			.BlockSize (BlockSize)
		) uFifo (
			.clk      (clk),
			.rst      (rst),
			.push     (push[i]),
			.pushData (samples[i]),
			.pop      (pop[i]),
			.popData  (fifoData[i]),
			.empty    (empty[i]),
			.done     (done[i]),
			.overflow (overflow[i])
		);
	end

	orbPacker uPacker (
		.clk      (clk),
		.rst      (rst),
		.done     (done),
		.empty    (empty),
		.pop      (pop),
		.fifoData (fifoData),
		.memWrite (memWrite),
		.busy     (busy)
	);

	orbFrameRam uFrameRam (
		.clk      (clk),
		.memWrite (memWrite),
		.rdAddr   (rdAddr),
		.rdData   (rdData)
	);

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int HalfPeriod  = 10,
	parameter int ResetCycles = 8
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;   // 20 ns period
	end

	initial begin
		rst = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/orbPacker_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module orbPackerAssertions (
	input logic                           clk,
	input logic                           rst,
	input logic [orbPkg::NumChannels-1:0] pop,
	input logic [orbPkg::NumChannels-1:0] empty,
	input orbPkg::memWriteT               memWrite
);
	import orbPkg::*;

	int failCount = 0;   // read by the testbench for its summary

	weSinglePulse: assert property (@(posedge clk) disable iff (!rst)
		memWrite.we |=> !memWrite.we)
	else begin
		$error("write enable stayed high for more than one cycle");
		failCount++;
	end

	popOneHot: assert property (@(posedge clk) disable iff (!rst) $onehot0(pop))
	else begin
		$error("more than one FIFO popped in the same cycle");
		failCount++;
	end

	popNotEmpty: assert property (@(posedge clk) disable iff (!rst) (pop & empty) == '0)
	else begin
		$error("pop issued to an empty FIFO");
		failCount++;
	end

endmodule

bind orbPacker orbPackerAssertions uPackerChecks (
	.clk      (clk),
	.rst      (rst),
	.pop      (pop),
	.empty    (empty),
	.memWrite (memWrite)
);

`default_nettype wire

// File: testbench/orbTests.svh
`ifndef ORB_TESTS_SVH
`define ORB_TESTS_SVH

task automatic testReset();
	checkEqual("reset busy", 0, busy);
	checkEqual("reset overflow", 0, overflow);
endtask

task automatic testRounding();
	codeT list[$];
	list = '{12'd4095, 12'd4088, 12'd4087, 12'd0, 12'd7, 12'd8, 12'd2047, 12'd2056};
	while (list.size() < 16) begin
		list.push_back(codeT'($urandom_range(4095)));
	end
	pushList(2'd0, list, 1'b1);
	waitIdle("rounding");
	verifyWritten("rounding");
endtask

task automatic testFast1Order();
	pushRandom(2'd0, 16, 1'b1);   // one full frame of even slots
	waitIdle("fast1 frame");
	verifyWritten("fast1 frame");
	pushRandom(2'd0, 4, 1'b1);    // spills into the next frame
	waitIdle("fast1 next block");
	verifyWritten("fast1 next block");
endtask

task automatic testFast2Order();
	pushRandom(2'd1, 16, 1'b1);   // 15 fill the frame, the last one wraps
	waitIdle("fast2");
	verifyWritten("fast2");
endtask

task automatic testSlowChannels();
	pushRandom(2'd2, 4, 1'b1);
	waitIdle("slow1");
	verifyWritten("slow1");
	pushRandom(2'd3, 4, 1'b1);
	waitIdle("slow2");
	verifyWritten("slow2");
endtask

task automatic testPriority();
	orbWordT got;
	int      polls;
	for (int i = 0; i < 4; i++) begin
		@(posedge clk);
		for (int ch = 0; ch < NumChannels; ch++) begin
			queueCode(chanIdxT'(ch), codeT'($urandom_range(4095)), 1'b1);
		end
	end
	@(posedge clk);
	codes <= '0;
	// entry 1 is the first fast2 word and entry 3 the first slow2 word
	got   = 'x;
	polls = 0;
	while (got !== expWords[1] && polls < 100) begin
		readWord(expAddrs[1], got);
		polls++;
	end
	if (got !== expWords[1]) begin
		errorCount++;
		$display("priority: first fast2 word never reached the frame memory");
	end
	readWord(expAddrs[3], got);
	checkEqual("priority slow2 still pending", 1, got !== expWords[3]);
	checkEqual("priority busy during drain", 1, busy);
	for (int i = 0; i < 4; i++) begin
		readWord(expAddrs[4 * i], got);
		checkEqual("priority fast1 written first", expWords[4 * i], got);
	end
	waitIdle("priority");
	verifyWritten("priority");
endtask

task automatic testOverflow();
	checkEqual("overflow before burst", 0, overflow);
	pushRandom(2'd3, 32, 1'b0);   // far faster than one word per four cycles
	waitIdle("overflow");
	checkEqual("overflow only on slow2", 4'b1000, overflow);
endtask

`endif

// File: testbench/orbTb.sv
`timescale 1ns/1ps
`default_nettype none

module orbTb;
	import orbPkg::*;

	localparam int TotalCodes     = 108;                       // codes pushed over all tests
	localparam int WatchdogCycles = TotalCodes * 10 + 1000;    // drain and readout margin
	localparam int IdleTimeout    = 400;

	logic                     clk;
	logic                     rst;
	codeInT [NumChannels-1:0] codes;
	orbAddrT                  rdAddr;
	orbWordT                  rdData;
	logic [NumChannels-1:0]   overflow;
	logic                     busy;

	orbAddrT expAddrs[$];          // where each recorded code should land
	orbWordT expWords[$];
	int      wordsDone [NumChannels];   // words sent so far per channel
	int      checkCount;
	int      errorCount;
	int      assertErrors;

	tbClock uClock (
		.clk (clk),
		.rst (rst)
	);

	orbTop #(
		.FifoDepth (16),
		.BlockSize (4)
	) u_dut (
		.clk      (clk),
		.rst      (rst),
		.codes    (codes),
		.rdAddr   (rdAddr),
		.rdData   (rdData),
		.overflow (overflow),
		.busy     (busy)
	);

	task automatic checkEqual(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// round half up on the 8-bit scale, clip at 255, then frame as 0 sample 000
	function automatic orbWordT roundedWord(input codeT code);
		int s;
		s = (int'(code) + 8) / 16;
		if (s > 255) begin
			s = 255;
		end
		return orbWordT'(s * 8);
	endfunction

	function automatic orbAddrT slotAddress(input chanIdxT ch, input int n);
		int frame;
		int slot;
		int k;
		case (ch)
			2'd0: begin
				k     = n % 16;
				frame = n / 16;
				slot  = (k < 8) ? 4 * k : 4 * (k - 8) + 2;   // 0, 4 .. 28 then 2 .. 30
			end
			2'd1: begin
				k     = n % 15;
				frame = n / 15;
				slot  = (k < 8) ? 4 * k + 1 : 4 * (k - 8) + 3;   // slot 31 is never used
			end
			2'd2: begin
				frame = 2 * n;
				slot  = ServiceSlot;
			end
			default: begin
				frame = 2 * n + 1;
				slot  = ServiceSlot;
			end
		endcase
		return orbAddrT'((frame % 64) * 32 + slot);
	endfunction

	task automatic queueCode(input chanIdxT ch, input codeT code, input bit record);
		codes[ch] <= {1'b1, code};
		if (record) begin
			expAddrs.push_back(slotAddress(ch, wordsDone[ch]));
			expWords.push_back(roundedWord(code));
			wordsDone[ch]++;
		end
	endtask

	task automatic pushList(input chanIdxT ch, input codeT list[$], input bit record);
		foreach (list[i]) begin
			@(posedge clk);
			queueCode(ch, list[i], record);
		end
		@(posedge clk);
		codes <= '0;
	endtask

	task automatic pushRandom(input chanIdxT ch, input int n, input bit record);
		codeT list[$];
		repeat (n) begin
			list.push_back(codeT'($urandom_range(4095)));
		end
		pushList(ch, list, record);
	endtask

	task automatic waitIdle(input string name);
		int cycles;
		int quiet;
		cycles = 0;
		quiet  = 0;
		repeat (4) @(negedge clk);   // the last code still has to reach its FIFO
		// the packer sits in Idle for one cycle between two channels
		while (quiet < 2 && cycles < IdleTimeout) begin
			quiet = busy ? 0 : quiet + 1;
			cycles++;
			@(negedge clk);
		end
		if (quiet < 2) begin
			errorCount++;
			$display("%s: packer did not go idle within %0d cycles", name, IdleTimeout);
		end
	endtask

	task automatic readWord(input orbAddrT addr, output orbWordT data);
		@(posedge clk);
		rdAddr <= addr;
		@(posedge clk);
		@(negedge clk);
		data = rdData;
	endtask

	task automatic verifyWritten(input string name);
		orbWordT got;
		for (int i = 0; i < expAddrs.size(); i++) begin
			readWord(expAddrs[i], got);
			checkEqual($sformatf("%s word %0d at %0h", name, i, expAddrs[i]), expWords[i], got);
		end
		expAddrs.delete();
		expWords.delete();
	endtask

	`include "orbTests.svh"

	initial begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("watchdog stopped the run after %0d cycles", WatchdogCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		codes      = '0;
		rdAddr     = '0;
		checkCount = 0;
		errorCount = 0;
		wordsDone  = '{default: 0};
		void'($urandom(54849));
		wait (rst === 1'b1);
		@(negedge clk);
		testReset();
		testRounding();
		testFast1Order();
		testFast2Order();
		testSlowChannels();
		testPriority();
		testOverflow();
		assertErrors = u_dut.uPacker.uPackerChecks.failCount;
		$display("%0d checks, %0d value errors, %0d assertion errors",
			checkCount, errorCount, assertErrors);
		if (errorCount == 0 && assertErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
design/orbPkg.sv
design/sampleAcquirer.sv
design/sampleFifo.sv
design/orbPacker.sv
design/orbFrameRam.sv
design/orbTop.sv
testbench/tbClock.sv
testbench/orbPacker_assertions.sv
testbench/orbTb.sv

// File: Bender.yml
package:
  name: orb_frame_packer

sources:
  - files:
      - design/orbPkg.sv
      - design/sampleAcquirer.sv
      - design/sampleFifo.sv
      - design/orbPacker.sv
      - design/orbFrameRam.sv
      - design/orbTop.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbClock.sv
      - testbench/orbPacker_assertions.sv
      - testbench/orbTb.sv
